// File: Makefile
TOP := noc_stats_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ns -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
verilog/noc_pkg.sv
verilog/xbar_switch.sv
verilog/packet_sink.sv
verilog/stats_readout.sv
verilog/noc_stats_top.sv
tb/noc_stats_properties.sv
tb/noc_stats_tb.sv

// File: tb/noc_stats_properties.sv
`timescale 1ns/1ns

module noc_stats_properties (
  input logic                      clk,
  input logic                      rst,
  input noc_pkg::packet_t          pkt_tx [noc_pkg::PORTS],
  input noc_pkg::packet_t          pkt_rx [noc_pkg::PORTS],
  input logic [noc_pkg::PORTS-1:0] inject_ready,
  input logic                      req,
  input logic                      ack
);

  for (genvar p = 0; p < noc_pkg::PORTS; p++) begin : g_port
    // An output register only ever holds packets for its own port
    routing_a: assert property (@(posedge clk) disable iff (rst)
      pkt_rx[p].valid |-> pkt_rx[p].dest == noc_pkg::PORT_W'(p))
      else $error("Output %0d holds a packet for port %0d", p, pkt_rx[p].dest);

    // Echo of an accepted packet implies ready was high at that edge
    accept_a: assert property (@(posedge clk) disable iff (rst)
      pkt_tx[p].valid |-> $past(inject_ready[p]))
      else $error("Input %0d accepted a packet while not ready", p);
  end

  ack_a: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a pending req");

endmodule

bind noc_stats_top noc_stats_properties u_props (
  .clk(clk),
  .rst(rst),
  .pkt_tx(pkt_tx),
  .pkt_rx(pkt_rx),
  .inject_ready(inject_ready),
  .req(req),
  .ack(ack)
);

// File: tb/noc_stats_tb.sv
`timescale 1ns/1ns

module noc_stats_tb;

  localparam int DEPTH          = 4;
  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = 400 * NUM_TESTS;
  localparam int QUIET_CYCLES   = 6;   // Latency 2 plus sink update and margin
  localparam int BURST_LEN      = 12;  // Packets per port in the back-pressure burst

  logic                       clk;
  logic                       rst;
  noc_pkg::packet_t           inject [noc_pkg::PORTS];
  logic [noc_pkg::PORTS-1:0]  inject_ready;
  logic                       measure;
  logic                       req;
  noc_pkg::stat_query_t       query;
  logic                       ack;
  logic [noc_pkg::STAT_W-1:0] rdata;

  noc_pkg::packet_t port_q [noc_pkg::PORTS][$];  // Schedule per input with idle slots as valid low
  noc_pkg::packet_t sent_q [$];                  // Packets sent while measuring

  logic [31:0] rng;
  string       test_name;
  int          check_errors;
  int          errors_before;
  int          tests_run;
  int          tests_failed;

  noc_stats_top #(.DEPTH(DEPTH)) UUT (
    .clk, .rst, .inject, .inject_ready, .measure, .req, .query, .ack, .rdata
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Reference model
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Stamp field of a sent_q entry holds its injection slot
  function automatic noc_pkg::stat_totals_t reference_totals();
    noc_pkg::stat_totals_t t;
    int                    ahead;
    t = '0;
    for (int j = 0; j < sent_q.size(); j++) begin
      ahead = 0;
      for (int i = 0; i < j; i++) begin
        if (sent_q[i].stamp == sent_q[j].stamp && sent_q[i].dest == sent_q[j].dest) ahead++;
      end
      t.rx_total      = t.rx_total + 32'd1;
      t.tx_total      = t.tx_total + 32'd1;
      t.latency_total = t.latency_total + 48'(2 + ahead);  // One extra cycle per packet ahead
      if (ahead > 0) t.buffered_total = t.buffered_total + 32'd1;
    end
    return t;
  endfunction

  function automatic logic [noc_pkg::PAIR_W-1:0] reference_pair(
    input logic [noc_pkg::PORT_W-1:0] src,
    input logic [noc_pkg::PORT_W-1:0] dst
  );
    logic [noc_pkg::PAIR_W-1:0] n;
    n = '0;
    for (int i = 0; i < sent_q.size(); i++) begin
      if (sent_q[i].source == src && sent_q[i].dest == dst) n = n + 1'b1;
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Compare tasks
  task automatic check_word(input string what, input logic [noc_pkg::STAT_W-1:0] expected,
                            input logic [noc_pkg::STAT_W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_packet_count(input string what,
                                    input logic [noc_pkg::PAIR_W-1:0] expected,
                                    input logic [noc_pkg::PAIR_W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      check_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Readout handshake
  task automatic read_stat(input noc_pkg::stat_query_t q,
                           output logic [noc_pkg::STAT_W-1:0] word);
    int waited;
    waited = 0;
    @(posedge clk);
    query <= q;
    req   <= 1'b1;
    do begin
      @(posedge clk);
      waited++;
    end while (!ack && waited < 20);
    if (!ack) begin
      $display("%s: no ack within 20 cycles of req", test_name);
      check_errors++;
    end
    word = rdata;
    req <= 1'b0;
    while (ack) @(posedge clk);  // Four-phase return to idle
  endtask

  task automatic read_total(input noc_pkg::stat_sel_t sel,
                            output logic [noc_pkg::STAT_W-1:0] word);
    noc_pkg::stat_query_t q;
    q     = '0;
    q.sel = sel;
    read_stat(q, word);
  endtask

  task automatic check_totals();
    noc_pkg::stat_totals_t      exp;
    logic [noc_pkg::STAT_W-1:0] word;
    exp = reference_totals();
    read_total(noc_pkg::SEL_RX_TOTAL, word);
    check_word("rx_total", noc_pkg::STAT_W'(exp.rx_total), word);
    read_total(noc_pkg::SEL_TX_TOTAL, word);
    check_word("tx_total", noc_pkg::STAT_W'(exp.tx_total), word);
    read_total(noc_pkg::SEL_LATENCY_TOTAL, word);
    check_word("latency_total", exp.latency_total, word);
    read_total(noc_pkg::SEL_FULL_TOTAL, word);
    check_word("full_total", noc_pkg::STAT_W'(exp.full_total), word);
    read_total(noc_pkg::SEL_NEARLY_FULL_TOTAL, word);
    check_word("nearly_full_total", noc_pkg::STAT_W'(exp.nearly_full_total), word);
    read_total(noc_pkg::SEL_BUFFERED_TOTAL, word);
    check_word("buffered_total", noc_pkg::STAT_W'(exp.buffered_total), word);
  endtask

  task automatic check_pairs();
    noc_pkg::stat_query_t       q;
    logic [noc_pkg::STAT_W-1:0] word;
    for (int s = 0; s < noc_pkg::PORTS; s++) begin
      for (int d = 0; d < noc_pkg::PORTS; d++) begin
        q     = '0;
        q.sel = noc_pkg::SEL_PAIR_RX;
        q.src = noc_pkg::PORT_W'(s);
        q.dst = noc_pkg::PORT_W'(d);
        read_stat(q, word);
        check_packet_count($sformatf("pair_rx[%0d][%0d]", s, d),
                           reference_pair(q.src, q.dst), word[noc_pkg::PAIR_W-1:0]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  task automatic add_packet(input logic [noc_pkg::PORT_W-1:0] port,
                            input logic [noc_pkg::PORT_W-1:0] dest,
                            input int slot, input bit record);
    noc_pkg::packet_t pkt;
    pkt         = '0;
    rng         = xorshift(rng);
    pkt.valid   = 1'b1;
    pkt.dest    = dest;
    pkt.payload = rng[15:0];
    port_q[port].push_back(pkt);
    if (record) begin
      pkt.source = port;
      pkt.stamp  = noc_pkg::STAMP_W'(slot);
      sent_q.push_back(pkt);
    end
  endtask

  // At most one packet per slot over all ports so no output is contended
  task automatic build_sparse(input int slots, input bit record);
    logic                       send;
    logic [noc_pkg::PORT_W-1:0] port;
    logic [noc_pkg::PORT_W-1:0] dest;
    for (int s = 0; s < slots; s++) begin
      rng  = xorshift(rng);
      send = rng[2];
      port = rng[1:0];
      dest = rng[4:3];
      for (int p = 0; p < noc_pkg::PORTS; p++) begin
        if (send && port == noc_pkg::PORT_W'(p)) add_packet(port, dest, s, record);
        else port_q[p].push_back('0);
      end
    end
  endtask

  // Pops the next entry once the current one is accepted or idle
  task automatic run_traffic();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int i = 0; i < noc_pkg::PORTS; i++) begin
        if (inject[i].valid && !inject_ready[i]) begin
          busy = 1'b1;
        end else if (port_q[i].size() > 0) begin
          inject[i] <= port_q[i].pop_front();
          busy = 1'b1;
        end else begin
          inject[i] <= '0;
        end
      end
    end
  endtask

  task automatic measure_on();
    @(posedge clk);
    measure <= 1'b1;
  endtask

  // Poll rx_total until every measured packet is counted and then stop measuring
  task automatic wait_drained();
    logic [noc_pkg::STAT_W-1:0] word;
    int                         polls;
    word  = '0;
    polls = 0;
    while (word != noc_pkg::STAT_W'(sent_q.size()) && polls < 40) begin
      read_total(noc_pkg::SEL_RX_TOTAL, word);
      polls++;
    end
    if (word != noc_pkg::STAT_W'(sent_q.size())) begin
      $display("%s: rx_total stuck at %0d with %0d packets sent",
               test_name, word, sent_q.size());
      check_errors++;
    end
    @(posedge clk);
    measure <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst     <= 1'b1;
    measure <= 1'b0;
    req     <= 1'b0;
    for (int p = 0; p < noc_pkg::PORTS; p++) begin
      inject[p] <= '0;
      port_q[p].delete();
    end
    sent_q.delete();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errors_before = check_errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (check_errors == errors_before) begin
      $display("Test %s ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, check_errors - errors_before);
    end
  endtask

  // Handshake idle and every input ready right after reset
  task automatic check_idle_outputs();
    if (ack !== 1'b0) begin
      $display("CHECK FAILED %s ack: expected 0, actual %b", test_name, ack);
      check_errors++;
    end
    if (inject_ready !== {noc_pkg::PORTS{1'b1}}) begin
      $display("CHECK FAILED %s inject_ready: expected %b, actual %b",
               test_name, {noc_pkg::PORTS{1'b1}}, inject_ready);
      check_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  initial begin
    logic [noc_pkg::STAT_W-1:0] rx;
    logic [noc_pkg::STAT_W-1:0] tx;
    logic [noc_pkg::STAT_W-1:0] full;
    logic [noc_pkg::STAT_W-1:0] nearly;
    clk          = 1'b0;
    rst          = 1'b1;
    measure      = 1'b0;
    req          = 1'b0;
    query        = '0;
    rng          = 32'hac7e;
    check_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int p = 0; p < noc_pkg::PORTS; p++) inject[p] = '0;

    apply_reset();
    start_test("reset_readout");
    check_idle_outputs();
    check_totals();  // All zero with no packets sent
    check_pairs();
    finish_test();

    apply_reset();
    start_test("sparse_random");
    measure_on();
    build_sparse(60, 1'b1);
    run_traffic();
    wait_drained();
    check_totals();
    check_pairs();
    finish_test();

    apply_reset();
    start_test("hotspot");
    measure_on();
    for (int p = 0; p < noc_pkg::PORTS; p++) add_packet(noc_pkg::PORT_W'(p), '0, 0, 1'b1);
    run_traffic();
    wait_drained();
    check_totals();  // Expect latency 14 and three buffered
    check_pairs();
    finish_test();

    apply_reset();
    start_test("back_pressure");
    measure_on();
    for (int n = 0; n < BURST_LEN; n++) begin
      for (int p = 0; p < noc_pkg::PORTS; p++) add_packet(noc_pkg::PORT_W'(p), 2'd1, n, 1'b1);
    end
    run_traffic();
    wait_drained();
    read_total(noc_pkg::SEL_TX_TOTAL, tx);
    read_total(noc_pkg::SEL_RX_TOTAL, rx);
    read_total(noc_pkg::SEL_FULL_TOTAL, full);
    read_total(noc_pkg::SEL_NEARLY_FULL_TOTAL, nearly);
    check_word("tx_total", noc_pkg::STAT_W'(sent_q.size()), tx);
    check_word("rx_total", noc_pkg::STAT_W'(sent_q.size()), rx);
    check_pairs();
    if (full == '0) begin
      $display("%s: full_total stayed zero under back-pressure", test_name);
      check_errors++;
    end
    if (nearly < full) begin
      $display("%s: nearly_full_total %0d below full_total %0d", test_name, nearly, full);
      check_errors++;
    end
    finish_test();

    apply_reset();
    start_test("measure_low");
    measure_on();
    build_sparse(30, 1'b1);
    run_traffic();
    wait_drained();
    build_sparse(30, 1'b0);  // Not recorded since measure is low
    run_traffic();
    repeat (QUIET_CYCLES) @(posedge clk);
    check_totals();
    check_pairs();
    finish_test();

    apply_reset();
    start_test("reset_clears");
    check_idle_outputs();
    check_totals();
    check_pairs();
    finish_test();

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, check_errors);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verilog/noc_pkg.sv
package noc_pkg;

  // Switch geometry
  localparam int PORTS   = 4;
  localparam int PORT_W  = 2;   // Port index width
  localparam int STAMP_W = 30;  // Time stamp width

  // Statistic words
  localparam int STAT_W = 48;
  localparam int PAIR_W = 16;   // Per source/destination counter

  // Packet as it travels through the switch
  typedef struct packed {
    logic               valid;
    logic [PORT_W-1:0]  source;    // Input port, set by switch
    logic [PORT_W-1:0]  dest;
    logic               buffered;  // Lost arbitration at least once
    logic [STAMP_W-1:0] stamp;     // Acceptance time
    logic [15:0]        payload;
  } packet_t;

  // Statistic selector for the readout
  typedef enum logic [2:0] {
    SEL_RX_TOTAL,
    SEL_TX_TOTAL,
    SEL_LATENCY_TOTAL,
    SEL_FULL_TOTAL,
    SEL_NEARLY_FULL_TOTAL,
    SEL_BUFFERED_TOTAL,
    SEL_PAIR_RX
  } stat_sel_t;

  typedef struct packed {
    stat_sel_t         sel;
    logic [PORT_W-1:0] src;  // Pair source, SEL_PAIR_RX only
    logic [PORT_W-1:0] dst;
  } stat_query_t;

  // Running totals kept by the sink
  typedef struct packed {
    logic [31:0] rx_total;
    logic [31:0] tx_total;
    logic [47:0] latency_total;
    logic [32:0] full_total;
    logic [32:0] nearly_full_total;
    logic [31:0] buffered_total;
  } stat_totals_t;

endpackage

// File: verilog/noc_stats_top.sv
`timescale 1ns/1ns

module noc_stats_top #(
  parameter int DEPTH = 4  // Entries per input FIFO
) (
  input  logic                       clk,
  input  logic                       rst,
  input  noc_pkg::packet_t           inject [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0]  inject_ready,
  input  logic                       measure,
  input  logic                       req,
  input  noc_pkg::stat_query_t       query,
  output logic                       ack,
  output logic [noc_pkg::STAT_W-1:0] rdata
);

  // Switch to sink
  noc_pkg::packet_t            pkt_tx [noc_pkg::PORTS];
  noc_pkg::packet_t            pkt_rx [noc_pkg::PORTS];
  logic [noc_pkg::STAMP_W-1:0] timestamp;
  logic [noc_pkg::PORTS-1:0]   net_full;
  logic [noc_pkg::PORTS-1:0]   nearly_full;

  // Sink to readout
  noc_pkg::stat_totals_t       totals;
  logic [noc_pkg::PORTS-1:0][noc_pkg::PORTS-1:0][noc_pkg::PAIR_W-1:0] pair_rx;

  xbar_switch #(.DEPTH(DEPTH)) u_switch (
    .clk, .rst,
    .inject, .inject_ready,
    .pkt_tx, .pkt_rx,
    .timestamp, .net_full, .nearly_full
  );

  packet_sink u_sink (
    .clk, .rst,
    .pkt_rx, .pkt_tx, .timestamp,
    .net_full, .nearly_full, .measure,
    .totals, .pair_rx
  );

  stats_readout u_readout (
    .clk, .rst,
    .req, .query, .totals, .pair_rx,
    .ack, .rdata
  );

endmodule

// File: verilog/packet_sink.sv
`timescale 1ns/1ns

module packet_sink (
  input  logic                        clk,
  input  logic                        rst,
  input  noc_pkg::packet_t            pkt_rx [noc_pkg::PORTS],
  input  noc_pkg::packet_t            pkt_tx [noc_pkg::PORTS],
  input  logic [noc_pkg::STAMP_W-1:0] timestamp,
  input  logic [noc_pkg::PORTS-1:0]   net_full,
  input  logic [noc_pkg::PORTS-1:0]   nearly_full,
  input  logic                        measure,
  output noc_pkg::stat_totals_t       totals,
  output logic [noc_pkg::PORTS-1:0][noc_pkg::PORTS-1:0][noc_pkg::PAIR_W-1:0] pair_rx
);

  // Per-cycle increments, all ports together
  logic [2:0]                  rx_inc;
  logic [2:0]                  tx_inc;
  logic [2:0]                  buf_inc;
  logic [2:0]                  full_inc;
  logic [2:0]                  nfull_inc;
  logic [noc_pkg::STAMP_W+1:0] lat_inc;

  //////////////////////////////////////////////////////////////////////
  // Sum this cycle's events over the four ports
  always_comb begin
    logic [noc_pkg::STAMP_W-1:0] lat;
    lat       = '0;
    rx_inc    = '0;
    tx_inc    = '0;
    buf_inc   = '0;
    full_inc  = '0;
    nfull_inc = '0;
    lat_inc   = '0;
    for (int k = 0; k < noc_pkg::PORTS; k++) begin
      if (pkt_rx[k].valid) begin
        lat     = timestamp - pkt_rx[k].stamp;  // Modulo the stamp width
        rx_inc  = rx_inc + 1'b1;
        lat_inc = lat_inc + (noc_pkg::STAMP_W+2)'(lat);
        if (pkt_rx[k].buffered) buf_inc = buf_inc + 1'b1;
      end
      if (pkt_tx[k].valid) tx_inc    = tx_inc + 1'b1;
      if (net_full[k])     full_inc  = full_inc + 1'b1;
      if (nearly_full[k])  nfull_inc = nfull_inc + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters, frozen while measure is low
  always_ff @(posedge clk) begin
    if (rst) begin
      totals  <= '0;
      pair_rx <= '0;
    end else if (measure) begin
      totals.rx_total          <= totals.rx_total + 32'(rx_inc);
      totals.tx_total          <= totals.tx_total + 32'(tx_inc);
      totals.latency_total     <= totals.latency_total + 48'(lat_inc);
      totals.buffered_total    <= totals.buffered_total + 32'(buf_inc);
      totals.full_total        <= totals.full_total + 33'(full_inc);
      totals.nearly_full_total <= totals.nearly_full_total + 33'(nfull_inc);

      // One entry per output port, so no two ports hit the same counter
      for (int k = 0; k < noc_pkg::PORTS; k++) begin
        if (pkt_rx[k].valid) begin
          pair_rx[pkt_rx[k].source][k] <= pair_rx[pkt_rx[k].source][k] + 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/stats_readout.sv
`timescale 1ns/1ns

module stats_readout (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  input  noc_pkg::stat_query_t       query,
  input  noc_pkg::stat_totals_t      totals,
  input  logic [noc_pkg::PORTS-1:0][noc_pkg::PORTS-1:0][noc_pkg::PAIR_W-1:0] pair_rx,
  output logic                       ack,
  output logic [noc_pkg::STAT_W-1:0] rdata
);

  logic [noc_pkg::STAT_W-1:0] sel_word;
  logic                       start;  // Request seen while idle

  // Statistic selection, zero-extended
  always_comb begin
    case (query.sel)
      noc_pkg::SEL_RX_TOTAL:
        sel_word = noc_pkg::STAT_W'(totals.rx_total);
      noc_pkg::SEL_TX_TOTAL:
        sel_word = noc_pkg::STAT_W'(totals.tx_total);
      noc_pkg::SEL_LATENCY_TOTAL:
        sel_word = noc_pkg::STAT_W'(totals.latency_total);
      noc_pkg::SEL_FULL_TOTAL:
        sel_word = noc_pkg::STAT_W'(totals.full_total);
      noc_pkg::SEL_NEARLY_FULL_TOTAL:
        sel_word = noc_pkg::STAT_W'(totals.nearly_full_total);
      noc_pkg::SEL_BUFFERED_TOTAL:
        sel_word = noc_pkg::STAT_W'(totals.buffered_total);
      noc_pkg::SEL_PAIR_RX:
        sel_word = noc_pkg::STAT_W'(pair_rx[query.src][query.dst]);
      default:
        sel_word = '0;
    endcase
  end

  assign start = req && !ack;

  //////////////////////////////////////////////////////////////////////
  // Four-phase responder, ack doubles as the state bit
  always_ff @(posedge clk) begin
    if (rst)              ack <= 1'b0;
    else if (start)       ack <= 1'b1;  // Idle to acknowledge
    else if (ack && !req) ack <= 1'b0;  // Host released
  end

  // Word held steady for the whole ack phase
  always_ff @(posedge clk) begin
    if (start) rdata <= sel_word;
  end

endmodule

// File: verilog/xbar_switch.sv
`timescale 1ns/1ns

module xbar_switch #(
  parameter int DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  noc_pkg::packet_t              inject [noc_pkg::PORTS],
  output logic [noc_pkg::PORTS-1:0]     inject_ready,
  output noc_pkg::packet_t              pkt_tx [noc_pkg::PORTS],
  output noc_pkg::packet_t              pkt_rx [noc_pkg::PORTS],
  output logic [noc_pkg::STAMP_W-1:0]   timestamp,
  output logic [noc_pkg::PORTS-1:0]     net_full,
  output logic [noc_pkg::PORTS-1:0]     nearly_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [noc_pkg::STAMP_W-1:0] time_next;
  logic [noc_pkg::PORTS-1:0]   accept;
  logic [noc_pkg::PORTS-1:0]   win;
  logic [noc_pkg::PORTS-1:0]   lose;
  logic [noc_pkg::PORTS-1:0]   grant_valid;
  logic [noc_pkg::PORT_W-1:0]  grant_idx [noc_pkg::PORTS];
  logic [noc_pkg::PORT_W-1:0]  last [noc_pkg::PORTS];   // Last input granted per output
  noc_pkg::packet_t            stamped [noc_pkg::PORTS];
  noc_pkg::packet_t            head [noc_pkg::PORTS];
  noc_pkg::packet_t            stage [noc_pkg::PORTS];  // Grant register per output
  noc_pkg::packet_t            mem [noc_pkg::PORTS][DEPTH];
  logic [PTR_W-1:0]            wr_ptr [noc_pkg::PORTS];
  logic [PTR_W-1:0]            rd_ptr [noc_pkg::PORTS];
  logic [CNT_W-1:0]            count [noc_pkg::PORTS];

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign time_next = timestamp + 1'b1;  // Time of the coming edge

  always_ff @(posedge clk) begin
    if (rst) timestamp <= '0;
    else     timestamp <= time_next;
  end

  //////////////////////////////////////////////////////////////////////
  // Input side
  always_comb begin
    for (int i = 0; i < noc_pkg::PORTS; i++) begin
      inject_ready[i] = count[i] != CNT_W'(DEPTH);
      net_full[i]     = count[i] == CNT_W'(DEPTH);
      nearly_full[i]  = count[i] >= CNT_W'(DEPTH - 1);
      accept[i]       = inject[i].valid && (count[i] != CNT_W'(DEPTH));
      head[i]         = mem[i][rd_ptr[i]];
      stamped[i]          = inject[i];
      stamped[i].source   = noc_pkg::PORT_W'(i);
      stamped[i].buffered = 1'b0;
      stamped[i].stamp    = time_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Round-robin arbiters, one per output
  always_comb begin
    logic [noc_pkg::PORT_W-1:0] idx;
    idx = '0;
    for (int o = 0; o < noc_pkg::PORTS; o++) begin
      grant_valid[o] = 1'b0;
      grant_idx[o]   = last[o];
      for (int k = 1; k <= noc_pkg::PORTS; k++) begin
        idx = last[o] + noc_pkg::PORT_W'(k);  // Search starts after last winner
        if (!grant_valid[o] && count[idx] != '0 && head[idx].dest == noc_pkg::PORT_W'(o)) begin
          grant_valid[o] = 1'b1;
          grant_idx[o]   = idx;
        end
      end
    end
    for (int i = 0; i < noc_pkg::PORTS; i++) begin
      win[i] = 1'b0;
      for (int o = 0; o < noc_pkg::PORTS; o++) begin
        if (grant_valid[o] && grant_idx[o] == noc_pkg::PORT_W'(i)) win[i] = 1'b1;
      end
      lose[i] = (count[i] != '0) && !win[i];  // Head waiting on its output
    end
  end

  // FIFO pointers and arbiter state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < noc_pkg::PORTS; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        count[i]  <= '0;
        last[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < noc_pkg::PORTS; i++) begin
        if (accept[i]) wr_ptr[i] <= ptr_inc(wr_ptr[i]);
        if (win[i])    rd_ptr[i] <= ptr_inc(rd_ptr[i]);
        case ({accept[i], win[i]})
          2'b10:   count[i] <= count[i] + 1'b1;
          2'b01:   count[i] <= count[i] - 1'b1;
          default: count[i] <= count[i];
        endcase
        if (grant_valid[i]) last[i] <= grant_idx[i];
      end
    end
  end

  // FIFO storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < noc_pkg::PORTS; i++) begin
      if (accept[i]) mem[i][wr_ptr[i]] <= stamped[i];
      if (lose[i])   mem[i][rd_ptr[i]].buffered <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Grant stage, output registers and injection echo
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < noc_pkg::PORTS; p++) begin
        stage[p].valid  <= 1'b0;
        pkt_rx[p].valid <= 1'b0;
        pkt_tx[p].valid <= 1'b0;
      end
    end else begin
      for (int p = 0; p < noc_pkg::PORTS; p++) begin
        stage[p]        <= head[grant_idx[p]];
        stage[p].valid  <= grant_valid[p];
        pkt_rx[p]       <= stage[p];
        pkt_tx[p]       <= stamped[p];
        pkt_tx[p].valid <= accept[p];  // Shown for one cycle
      end
    end
  end

endmodule
